// ==== Makefile ====
TOP := tb_wb_register_bank

.PHONY: sim clean

# The run passes only when the pass message shows up in the simulator output
sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f build.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Verification passed$$"

clean:
	rm -rf obj_dir

// ==== build.f ====
logic/wb_reg_pkg.sv
logic/wb_slot_if.sv
logic/wb_addr_decoder.sv
logic/wb_register_simulink2ppc.sv
logic/wb_register_ppc2simulink.sv
logic/wb_register_bank.sv
verification/tb_wb_register_bank.sv

// ==== logic/wb_addr_decoder.sv ====
`timescale 1ns/1ps

module wb_addr_decoder #(
  parameter int NUM_IN  = 1,
  parameter int NUM_OUT = 1
) (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  wb_reg_pkg::wb_addr_t wb_adr_i,
  input  wb_reg_pkg::wb_word_t wb_dat_i,
  input  wb_reg_pkg::wb_sel_t  wb_sel_i,
  input  logic                 wb_we_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  output wb_reg_pkg::wb_word_t wb_dat_o,
  output logic                 wb_ack_o,
  output logic                 wb_err_o,
  wb_slot_if.decoder           status_o [NUM_IN],
  wb_slot_if.decoder           ctrl_o [NUM_OUT]
);

  logic [wb_reg_pkg::SLOT_IDX_W-1:0] slot_idx;
  logic                              in_window;
  logic                              accept;
  logic                              mapped;
  logic [NUM_IN-1:0]                 status_hit;
  logic [NUM_OUT-1:0]                ctrl_hit;
  wb_reg_pkg::wb_word_t              status_rdata [NUM_IN];
  wb_reg_pkg::wb_word_t              ctrl_rdata [NUM_OUT];
  wb_reg_pkg::wb_word_t              sel_rdata;
  wb_reg_pkg::wb_word_t              rdata_q;
  logic                              ack_q;
  logic                              err_q;

  assign slot_idx  = wb_reg_pkg::slot_index(wb_adr_i);
  assign in_window = wb_reg_pkg::addr_in_window(wb_adr_i);

  // A new cycle is taken only when no response went out on the previous edge
  assign accept = wb_stb_i && wb_cyc_i && !(ack_q || err_q);
  assign mapped = (|status_hit) || (|ctrl_hit);

  for (genvar i = 0; i < NUM_IN; i++) begin : g_status
    assign status_hit[i]         = in_window && (int'(slot_idx) == i);
    assign status_o[i].acc_stb   = accept && status_hit[i];
    assign status_o[i].acc_we    = wb_we_i;
    assign status_o[i].acc_sel   = wb_sel_i;
    assign status_o[i].acc_wdata = wb_dat_i;
    assign status_rdata[i]       = status_o[i].slot_rdata;
  end

  for (genvar j = 0; j < NUM_OUT; j++) begin : g_ctrl
    assign ctrl_hit[j]         = in_window && (int'(slot_idx) == NUM_IN + j);  // Control follows status
    assign ctrl_o[j].acc_stb   = accept && ctrl_hit[j];
    assign ctrl_o[j].acc_we    = wb_we_i;
    assign ctrl_o[j].acc_sel   = wb_sel_i;
    assign ctrl_o[j].acc_wdata = wb_dat_i;
    assign ctrl_rdata[j]       = ctrl_o[j].slot_rdata;
  end

  always_comb begin
    sel_rdata = '0;  // Unmapped slots read as zero
    for (int i = 0; i < NUM_IN; i++) begin
      if (status_hit[i]) begin
        sel_rdata = status_rdata[i];
      end
    end
    for (int j = 0; j < NUM_OUT; j++) begin
      if (ctrl_hit[j]) begin
        sel_rdata = ctrl_rdata[j];
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= accept && mapped;  // Writes to status slots are acked and dropped
      err_q <= accept && !mapped;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (accept) begin
      rdata_q <= sel_rdata;  // Word of the accessed slot at acceptance
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_err_o = err_q;
  assign wb_dat_o = ack_q ? rdata_q : '0;  // Data bus is quiet outside an ack

endmodule

// ==== logic/wb_reg_pkg.sv ====
package wb_reg_pkg;

  // Bus words are numbered from the MSB, bit 0 is the most significant bit
  typedef logic [0:31] wb_word_t;

  typedef logic [0:31] wb_addr_t;  // Byte address on the bus

  typedef logic [0:3] wb_sel_t;  // Bit 0 selects the most significant byte

  localparam int WORD_ADDR_LSB = 2;  // Byte offset bits inside a word
  localparam int SLOT_IDX_W = 4;  // Up to 16 register slots

  // Slot index taken from the word address
  function automatic logic [SLOT_IDX_W-1:0] slot_index(input wb_addr_t adr);
    return SLOT_IDX_W'(adr >> WORD_ADDR_LSB);
  endfunction

  // High when no address bit above the slot index is set
  function automatic logic addr_in_window(input wb_addr_t adr);
    return (adr >> (WORD_ADDR_LSB + SLOT_IDX_W)) == '0;
  endfunction

endpackage

// ==== logic/wb_register_bank.sv ====
`timescale 1ns/1ps

module wb_register_bank #(
  parameter int NUM_IN  = 3,
  parameter int NUM_OUT = 2
) (
  input  logic                                wb_clk_i,
  input  logic                                wb_rst_i,
  input  wb_reg_pkg::wb_addr_t                wb_adr_i,
  input  wb_reg_pkg::wb_word_t                wb_dat_i,
  input  wb_reg_pkg::wb_sel_t                 wb_sel_i,
  input  logic                                wb_we_i,
  input  logic                                wb_cyc_i,
  input  logic                                wb_stb_i,
  output wb_reg_pkg::wb_word_t                wb_dat_o,
  output logic                                wb_ack_o,
  output logic                                wb_err_o,
  input  logic                                user_clk,
  input  wb_reg_pkg::wb_word_t [NUM_IN-1:0]  user_status_i,
  output wb_reg_pkg::wb_word_t [NUM_OUT-1:0] user_ctrl_o
);

  wb_slot_if status_if [NUM_IN] ();  // Slots 0 to NUM_IN-1
  wb_slot_if ctrl_if [NUM_OUT] ();  // Slots right after the status block

  wb_addr_decoder #(
    .NUM_IN  (NUM_IN),
    .NUM_OUT (NUM_OUT)
  ) u_decoder (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_we_i  (wb_we_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o),
    .status_o (status_if),
    .ctrl_o   (ctrl_if)
  );

  for (genvar i = 0; i < NUM_IN; i++) begin : g_status
    wb_register_simulink2ppc u_status (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .slot_i      (status_if[i]),
      .user_clk    (user_clk),
      .user_data_i (user_status_i[i])
    );
  end

  for (genvar j = 0; j < NUM_OUT; j++) begin : g_ctrl
    wb_register_ppc2simulink u_ctrl (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .slot_i      (ctrl_if[j]),
      .user_clk    (user_clk),
      .user_ctrl_o (user_ctrl_o[j])
    );
  end

endmodule

// ==== logic/wb_register_ppc2simulink.sv ====
`timescale 1ns/1ps

module wb_register_ppc2simulink (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  wb_slot_if.slot              slot_i,
  input  logic                 user_clk,
  output wb_reg_pkg::wb_word_t user_ctrl_o
);

  wb_reg_pkg::wb_word_t bus_copy;  // Value last written from the bus
  wb_reg_pkg::wb_word_t xfer_buf;  // Frozen while a transfer runs
  logic                 write_en;
  logic                 pending;  // Bus copy differs from what was sent
  logic                 launch;
  logic                 request;
  logic                 ready;
  logic                 ready_meta;
  logic                 ready_sync;
  logic                 request_meta;
  logic                 request_sync;
  logic                 rst_meta;
  logic                 rst_sync;  // wb_rst_i seen in the user domain

  // Bus clock domain

  assign write_en = slot_i.acc_stb && slot_i.acc_we;

  // A round is busy from request up until ready has dropped again
  assign launch = pending && !request && !ready_sync;

  always_ff @(posedge wb_clk_i) begin
    ready_meta <= ready;
    ready_sync <= ready_meta;
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      bus_copy <= '0;
      pending  <= 1'b0;
      request  <= 1'b0;
    end else begin
      for (int b = 0; b < 4; b++) begin
        if (write_en && slot_i.acc_sel[b]) begin
          bus_copy[b*8 +: 8] <= slot_i.acc_wdata[b*8 +: 8];  // Byte 0 is the MSB byte
        end
      end
      if (write_en) begin
        pending <= 1'b1;  // Wins over launch so a late write goes next round
      end else if (launch) begin
        pending <= 1'b0;
      end
      if (launch) begin
        request <= 1'b1;
      end else if (ready_sync) begin
        request <= 1'b0;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (launch) begin
      xfer_buf <= bus_copy;
    end
  end

  assign slot_i.slot_rdata = bus_copy;

  // User clock domain

  always_ff @(posedge user_clk) begin
    rst_meta     <= wb_rst_i;
    rst_sync     <= rst_meta;
    request_meta <= request;
    request_sync <= request_meta;
  end

  always_ff @(posedge user_clk) begin
    if (rst_sync) begin
      user_ctrl_o <= '0;
      ready       <= 1'b0;
    end else begin
      if (request_sync && !ready) begin
        user_ctrl_o <= xfer_buf;  // Buffer is held still until ready returns
      end
      if (request_sync) begin
        ready <= 1'b1;
      end else begin
        ready <= 1'b0;
      end
    end
  end

endmodule

// ==== logic/wb_register_simulink2ppc.sv ====
`timescale 1ns/1ps

module wb_register_simulink2ppc (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  wb_slot_if.slot              slot_i,
  input  logic                 user_clk,
  input  wb_reg_pkg::wb_word_t user_data_i
);

  // Four-phase handshake, the bus side asks and the user side answers
  logic                 request;  // Bus domain, asks for a fresh sample
  logic                 ready;  // User domain, a sample is held
  logic                 ready_meta;
  logic                 ready_sync;
  logic                 request_meta;
  logic                 request_sync;
  wb_reg_pkg::wb_word_t user_hold;  // User domain holding register
  wb_reg_pkg::wb_word_t bus_buffer;  // Bus domain copy shown on reads

  // Bus clock domain

  always_ff @(posedge wb_clk_i) begin
    ready_meta <= ready;
    ready_sync <= ready_meta;
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      request <= 1'b0;
    end else if (ready_sync) begin
      request <= 1'b0;  // Sample arrived, drop the request
    end else begin
      request <= 1'b1;  // Keep asking for the next sample
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (ready_sync && request) begin
      bus_buffer <= user_hold;  // User word is stable while ready is high
    end
  end

  assign slot_i.slot_rdata = bus_buffer;  // Read only, bus writes have no effect

  // User clock domain

  always_ff @(posedge user_clk) begin
    request_meta <= request;
    request_sync <= request_meta;
  end

  always_ff @(posedge user_clk) begin
    if (request_sync && !ready) begin
      user_hold <= user_data_i;  // Sample once per request
    end
  end

  always_ff @(posedge user_clk) begin
    if (request_sync) begin
      ready <= 1'b1;
    end else begin
      ready <= 1'b0;
    end
  end

endmodule

// ==== logic/wb_slot_if.sv ====
`timescale 1ns/1ps

// One decoded bus access towards a register slot, all on wb_clk_i
interface wb_slot_if;

  logic                 acc_stb;  // Single cycle, the slot must act on it at once
  logic                 acc_we;
  wb_reg_pkg::wb_sel_t  acc_sel;
  wb_reg_pkg::wb_word_t acc_wdata;
  wb_reg_pkg::wb_word_t slot_rdata;  // Word the slot currently shows on the bus

  modport decoder (
    output acc_stb,
    output acc_we,
    output acc_sel,
    output acc_wdata,
    input  slot_rdata
  );

  modport slot (
    input  acc_stb,
    input  acc_we,
    input  acc_sel,
    input  acc_wdata,
    output slot_rdata
  );

endinterface

// ==== verification/tb_wb_register_bank.sv ====
`timescale 1ns/1ps

module tb_wb_register_bank;

  localparam int NUM_IN        = 3;
  localparam int NUM_OUT       = 2;
  localparam int NUM_SLOTS     = NUM_IN + NUM_OUT;
  localparam int STATUS_ROUNDS = 20;
  localparam int CTRL_BURSTS   = 8;
  localparam int BURST_LEN     = 4;
  localparam int SETTLE_CYCLES = 40;  // Covers two full handshake rounds
  localparam int B2B_COUNT     = 20;
  // The status test needs about 20 x (40 + 10) cycles, the control tests about 500 more
  // and the rest under 200, so all tests end near 1700 cycles
  localparam int TIMEOUT_CYCLES = 4000;

  logic                                 wb_clk_i;
  logic                                 wb_rst_i;
  wb_reg_pkg::wb_addr_t                 wb_adr_i;
  wb_reg_pkg::wb_word_t                 wb_dat_i;
  wb_reg_pkg::wb_sel_t                  wb_sel_i;
  logic                                 wb_we_i;
  logic                                 wb_cyc_i;
  logic                                 wb_stb_i;
  wb_reg_pkg::wb_word_t                 wb_dat_o;
  logic                                 wb_ack_o;
  logic                                 wb_err_o;
  logic                                 user_clk;
  wb_reg_pkg::wb_word_t [NUM_IN-1:0]   user_status_i;
  wb_reg_pkg::wb_word_t [NUM_OUT-1:0]  user_ctrl_o;

  wb_reg_pkg::wb_word_t status_model [NUM_IN];  // Last stable user_status_i words
  wb_reg_pkg::wb_word_t ctrl_model [NUM_OUT];  // Expected bus copy of each control slot
  int                   cycle_count;
  int                   test_errors;
  int                   tests_passed;
  int                   tests_failed;

  wb_register_bank #(
    .NUM_IN  (NUM_IN),
    .NUM_OUT (NUM_OUT)
  ) UUT (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_sel_i      (wb_sel_i),
    .wb_we_i       (wb_we_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .wb_err_o      (wb_err_o),
    .user_clk      (user_clk),
    .user_status_i (user_status_i),
    .user_ctrl_o   (user_ctrl_o)
  );

  always #30 wb_clk_i = ~wb_clk_i;
  always #50 user_clk = ~user_clk;

  always @(posedge wb_clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d bus clock cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  // Byte merge as the bus defines it, select bit 0 covers the top byte
  function automatic wb_reg_pkg::wb_word_t merge_bytes(input wb_reg_pkg::wb_word_t old_word,
                                                      input wb_reg_pkg::wb_word_t new_word,
                                                      input wb_reg_pkg::wb_sel_t  sel);
    logic [31:0] mask;
    mask = '0;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        mask = mask | (32'hFF00_0000 >> (8 * b));
      end
    end
    return (new_word & mask) | (old_word & ~mask);
  endfunction

  // Random byte offset checks that the low address bits are ignored
  function automatic wb_reg_pkg::wb_addr_t word_addr(input int idx);
    return wb_reg_pkg::wb_addr_t'(idx * 4 + int'($urandom_range(0, 3)));
  endfunction

  function automatic wb_reg_pkg::wb_word_t model_word(input int idx);
    if (idx < NUM_IN) begin
      return status_model[idx];
    end
    return ctrl_model[idx - NUM_IN];
  endfunction

  task automatic drive_access(input wb_reg_pkg::wb_addr_t adr, input logic we,
                              input wb_reg_pkg::wb_sel_t sel, input wb_reg_pkg::wb_word_t wdata);
    wb_adr_i <= adr;
    wb_we_i  <= we;
    wb_sel_i <= sel;
    wb_dat_i <= wdata;
    wb_stb_i <= 1'b1;
    wb_cyc_i <= 1'b1;
  endtask

  // Outputs are sampled on the falling edge, half a cycle after the DUT updates them
  task automatic wait_response(output logic ack, output logic err,
                               output wb_reg_pkg::wb_word_t rdata);
    do begin
      @(negedge wb_clk_i);
    end while (!(wb_ack_o || wb_err_o));
    ack   = wb_ack_o;
    err   = wb_err_o;
    rdata = wb_dat_o;
  endtask

  task automatic bus_access(input wb_reg_pkg::wb_addr_t adr, input logic we,
                            input wb_reg_pkg::wb_sel_t sel, input wb_reg_pkg::wb_word_t wdata,
                            output logic ack, output logic err,
                            output wb_reg_pkg::wb_word_t rdata);
    @(posedge wb_clk_i);
    drive_access(adr, we, sel, wdata);
    wait_response(ack, err, rdata);
    @(posedge wb_clk_i);
    wb_stb_i <= 1'b0;
    wb_cyc_i <= 1'b0;
  endtask

  task automatic check_read(input string name, input int idx);
    logic                 ack;
    logic                 err;
    wb_reg_pkg::wb_word_t rdata;
    bus_access(word_addr(idx), 1'b0, 4'hF, wb_reg_pkg::wb_word_t'($urandom), ack, err, rdata);
    if (!ack || err) begin
      $display("Error: %s: read of slot %0d got ack %b and err %b instead of an ack",
               name, idx, ack, err);
      test_errors++;
    end else if (rdata !== model_word(idx)) begin
      $display("Error: %s: slot %0d expected %h actual %h", name, idx, model_word(idx), rdata);
      test_errors++;
    end
    // The data bus must fall back to zero once the ack is gone
    @(negedge wb_clk_i);
    if (wb_dat_o !== '0) begin
      $display("Error: %s: wb_dat_o after the ack expected %h actual %h",
               name, 32'h0, wb_dat_o);
      test_errors++;
    end
  endtask

  task automatic write_burst(input string name, input int count, input logic read_back);
    logic                 ack;
    logic                 err;
    wb_reg_pkg::wb_word_t rdata;
    wb_reg_pkg::wb_word_t data;
    wb_reg_pkg::wb_sel_t  sel;
    int                   slot;
    for (int n = 0; n < count; n++) begin
      slot = int'($urandom_range(0, NUM_OUT - 1));
      sel  = 4'($urandom);
      data = $urandom;
      bus_access(word_addr(NUM_IN + slot), 1'b1, sel, data, ack, err, rdata);
      if (!ack || err) begin
        $display("Error: %s: write to control slot %0d was not acknowledged", name, slot);
        test_errors++;
      end
      ctrl_model[slot] = merge_bytes(ctrl_model[slot], data, sel);
      if (read_back) begin
        check_read(name, NUM_IN + slot);
      end
    end
  endtask

  task automatic check_transfer(input string name);
    repeat (SETTLE_CYCLES) @(posedge wb_clk_i);
    @(negedge user_clk);
    for (int j = 0; j < NUM_OUT; j++) begin
      if (user_ctrl_o[j] !== ctrl_model[j]) begin
        $display("Error: %s: user_ctrl_o[%0d] expected %h actual %h",
                 name, j, ctrl_model[j], user_ctrl_o[j]);
        test_errors++;
      end
    end
  endtask

  task automatic run_back_to_back(input string name, input int count);
    logic                 ack;
    logic                 err;
    logic                 we;
    wb_reg_pkg::wb_word_t rdata;
    wb_reg_pkg::wb_word_t data;
    wb_reg_pkg::wb_sel_t  sel;
    int                   idx;
    @(posedge wb_clk_i);
    for (int k = 0; k < count; k++) begin
      idx  = int'($urandom_range(0, NUM_SLOTS - 1));
      we   = (idx >= NUM_IN) && ($urandom_range(0, 1) == 1);
      sel  = 4'($urandom);
      data = $urandom;
      drive_access(word_addr(idx), we, sel, data);  // stb stays high between accesses
      wait_response(ack, err, rdata);
      if (ack && err) begin
        $display("Error: %s: access %0d saw ack and err together", name, k);
        test_errors++;
      end else if (!ack) begin
        $display("Error: %s: access %0d to slot %0d was not acknowledged", name, k, idx);
        test_errors++;
      end else if (!we && rdata !== model_word(idx)) begin
        $display("Error: %s: slot %0d expected %h actual %h", name, idx, model_word(idx), rdata);
        test_errors++;
      end
      if (we) begin
        ctrl_model[idx - NUM_IN] = merge_bytes(ctrl_model[idx - NUM_IN], data, sel);
      end
      @(posedge wb_clk_i);
    end
    wb_stb_i <= 1'b0;
    wb_cyc_i <= 1'b0;
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      $display("Test %s passed", name);
      tests_passed++;
    end else begin
      $display("Test %s failed with %0d errors", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  initial begin
    logic                 ack;
    logic                 err;
    wb_reg_pkg::wb_word_t rdata;
    wb_reg_pkg::wb_addr_t adr;
    wb_clk_i      = 1'b0;
    user_clk      = 1'b0;
    wb_rst_i      = 1'b1;
    wb_adr_i      = '0;
    wb_dat_i      = '0;
    wb_sel_i      = '0;
    wb_we_i       = 1'b0;
    wb_cyc_i      = 1'b0;
    wb_stb_i      = 1'b0;
    user_status_i = '0;
    cycle_count   = 0;
    test_errors   = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    void'($urandom(22));
    for (int i = 0; i < NUM_IN; i++) begin
      status_model[i] = '0;
    end
    for (int j = 0; j < NUM_OUT; j++) begin
      ctrl_model[j] = '0;
    end

    repeat (4) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;

    // Give the user side time to see the synchronized reset
    repeat (10) @(posedge wb_clk_i);
    @(negedge wb_clk_i);
    if (wb_ack_o !== 1'b0 || wb_err_o !== 1'b0) begin
      $display("Error: reset_idle: ack err expected 0 0 actual %b %b", wb_ack_o, wb_err_o);
      test_errors++;
    end
    if (wb_dat_o !== '0) begin
      $display("Error: reset_idle: wb_dat_o expected %h actual %h", 32'h0, wb_dat_o);
      test_errors++;
    end
    for (int j = 0; j < NUM_OUT; j++) begin
      if (user_ctrl_o[j] !== '0) begin
        $display("Error: reset_idle: user_ctrl_o[%0d] expected %h actual %h",
                 j, 32'h0, user_ctrl_o[j]);
        test_errors++;
      end
    end
    finish_test("reset_idle");

    for (int r = 0; r < STATUS_ROUNDS; r++) begin
      @(posedge user_clk);
      for (int i = 0; i < NUM_IN; i++) begin
        status_model[i] = $urandom;
        user_status_i[i] <= status_model[i];
      end
      repeat (SETTLE_CYCLES) @(posedge wb_clk_i);
      for (int i = 0; i < NUM_IN; i++) begin
        check_read("status_read", i);
      end
    end
    finish_test("status_read");

    write_burst("ctrl_write", 2 * BURST_LEN, 1'b1);
    finish_test("ctrl_write");

    for (int b = 0; b < CTRL_BURSTS; b++) begin
      write_burst("ctrl_transfer", BURST_LEN, 1'b0);
      check_transfer("ctrl_transfer");
    end
    finish_test("ctrl_transfer");

    for (int n = 0; n < 16; n++) begin
      if ($urandom_range(0, 1) == 1) begin
        adr = word_addr(int'($urandom_range(NUM_SLOTS, 15)));
      end else begin
        adr = $urandom | 32'h0000_0040;  // Outside the 16 slot window
      end
      bus_access(adr, 1'($urandom), 4'($urandom), $urandom, ack, err, rdata);
      if (!err || ack) begin
        $display("Error: address_map: access to %h got ack %b and err %b instead of an err",
                 adr, ack, err);
        test_errors++;
      end
      if (rdata !== '0) begin
        $display("Error: address_map: data at %h expected %h actual %h", adr, 32'h0, rdata);
        test_errors++;
      end
    end
    for (int i = 0; i < NUM_IN; i++) begin
      bus_access(word_addr(i), 1'b1, 4'hF, $urandom, ack, err, rdata);
      if (!ack || err) begin
        $display("Error: address_map: write to status slot %0d was not acknowledged", i);
        test_errors++;
      end
      check_read("address_map", i);
    end
    finish_test("address_map");

    run_back_to_back("back_to_back", B2B_COUNT);
    check_transfer("back_to_back");
    finish_test("back_to_back");

    $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
